/* Makefile */
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
EXE       ?= V$(TOP)
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= TB PASSED

.PHONY: sim clean

# the run passes only if the pass line appears in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(EXE) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/$(EXE))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/cache_tb_util.svh */
`ifndef CACHE_TB_UTIL_SVH
`define CACHE_TB_UTIL_SVH

// one model word per address bits 13..2, aliasing like line_mem
logic [31:0] ref_mem [4096];
bit          ref_written [4096];
logic [31:0] rng_state;
int          check_cnt;
int          err_cnt;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

function automatic int model_slot(input logic [31:0] addr);
    return int'(addr[13:2]);
endfunction

// strobed lanes take the new bytes
function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                            input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int k = 0; k < 4; k++) begin
        if (strb[k]) res[8*k +: 8] = data[8*k +: 8];
    end
    return res;
endfunction

function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                    input logic [3:0] strb);
    ref_mem[model_slot(addr)]     = merge_bytes(ref_mem[model_slot(addr)], data, strb);
    ref_written[model_slot(addr)] = 1'b1;
endfunction

function automatic bit model_has(input logic [31:0] addr);
    return ref_written[model_slot(addr)];
endfunction

function automatic logic [31:0] expected_read(input logic [31:0] addr);
    return ref_mem[model_slot(addr)];
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    check_cnt++;
    if (actual !== expected) begin
        err_cnt++;
        $display("ERR %s expected %08h actual %08h", name, expected, actual);
    end
endtask

`endif

/* bench/cache_tb.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_tb;

    localparam int WAIT_LIMIT = 200;
    localparam logic [`TAG_W-1:0] TAG_BASE = 20'h5aa00;  // only tag bits 1:0 vary

    logic                 clk, resetn, valid, op;
    logic [`INDEX_W-1:0]  index;
    logic [`TAG_W-1:0]    tag;
    logic [`OFFSET_W-1:0] offset;
    cache_pkg::strb_t     wstrb;
    cache_pkg::word_t     wdata;
    logic                 addr_ok, data_ok;
    cache_pkg::word_t     rdata;

    // one entry per accepted request, retired at its data_ok
    bit          pend_rd [$];
    logic [31:0] pend_exp [$];
    string       pend_name [$];

    int  timeouts;
    bit  hung;  // remaining stimulus is skipped
    cache_pkg::main_state_t dbg_state;

    `include "cache_tb_util.svh"

    cache_top dut_i (
        .clk     (clk),
        .resetn  (resetn),
        .valid   (valid),
        .op      (op),
        .index   (index),
        .tag     (tag),
        .offset  (offset),
        .wstrb   (wstrb),
        .wdata   (wdata),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] line_addr(input int t, input int set, input int word);
        return {TAG_BASE + 20'(t), 8'(set), 2'(word), 2'b00};
    endfunction

    task automatic report_hang(input string what, input string name);
        hung = 1'b1;
        timeouts++;
        dbg_state = dut_i.u_cache.state;
        $display("timeout waiting for %s in test %s, cache state %s", what, name,
                 dbg_state.name());
    endtask

    task automatic send_request(input logic wr, input logic [31:0] addr, input logic [3:0] strb,
                                input logic [31:0] data, input string name);
        int waited;
        bit taken;
        waited = 0;
        taken  = 1'b0;
        if (!hung) begin
            @(negedge clk);
            valid  = 1'b1;
            op     = wr;
            tag    = addr[31:12];
            index  = addr[11:4];
            offset = addr[3:0];
            wstrb  = wr ? strb : 4'h0;
            wdata  = data;
            // addr_ok looked at late in the cycle, just before the accepting edge
            while (!taken && waited < WAIT_LIMIT) begin
                #45;
                if (addr_ok) begin
                    taken = 1'b1;
                end else begin
                    waited++;
                    @(negedge clk);
                end
            end
            if (!taken) begin
                report_hang("addr_ok", name);
            end else begin
                if (pend_rd.size() > 0) begin
                    err_cnt++;
                    $display("test %s: request accepted while another still waits for data_ok",
                             name);
                end
                pend_rd.push_back(!wr);
                pend_name.push_back(name);
                if (wr) begin
                    model_write(addr, data, strb);
                    pend_exp.push_back(32'h0);
                end else begin
                    pend_exp.push_back(expected_read(addr));
                end
            end
        end
    endtask

    task automatic wait_all_done(input string name);
        int waited;
        waited = 0;
        if (!hung) begin
            @(negedge clk);
            valid = 1'b0;
            while (pend_rd.size() > 0 && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (pend_rd.size() > 0) report_hang("data_ok", name);
        end
    endtask

    // retire requests in order, reads compared against the model
    initial begin
        forever begin
            @(negedge clk);
            #40;  // outputs settled, before the request process looks
            if (resetn && data_ok) begin
                if (pend_rd.size() == 0) begin
                    err_cnt++;
                    $display("data_ok arrived with no request pending");
                end else begin
                    if (pend_rd[0]) check_value(pend_name[0], pend_exp[0], rdata);
                    void'(pend_rd.pop_front());
                    void'(pend_exp.pop_front());
                    void'(pend_name.pop_front());
                end
            end
        end
    end

    task automatic run_fill_and_strobes();
        logic [31:0] d;
        logic [31:0] r;
        for (int s = 10; s < 14; s++) begin
            for (int w = 0; w < 4; w++) begin
                d = next_rand();
                send_request(1'b1, line_addr(0, s, w), 4'hf, d, "write_miss_read_hit");
            end
        end
        for (int s = 10; s < 14; s++) begin
            for (int w = 0; w < 4; w++) begin
                send_request(1'b0, line_addr(0, s, w), 4'h0, 32'h0, "write_miss_read_hit");
            end
        end
        for (int w = 0; w < 4; w++) begin  // hits
            r = next_rand();
            d = next_rand();
            send_request(1'b1, line_addr(0, 11, w), r[3:0], d, "byte_strobe_hit");
            send_request(1'b0, line_addr(0, 11, w), 4'h0, 32'h0, "byte_strobe_hit");
        end
        // tags 1 and 2 push tag 0 out of set 12
        send_request(1'b1, line_addr(1, 12, 0), 4'hf, next_rand(), "byte_strobe_miss");
        send_request(1'b1, line_addr(2, 12, 0), 4'hf, next_rand(), "byte_strobe_miss");
        for (int w = 0; w < 4; w++) begin
            r = next_rand();
            d = next_rand();
            send_request(1'b1, line_addr(0, 12, w), r[7:4], d, "byte_strobe_miss");
            send_request(1'b0, line_addr(0, 12, w), 4'h0, 32'h0, "byte_strobe_miss");
        end
        wait_all_done("byte_strobe_miss");
    endtask

    task automatic run_read_after_write();
        logic [31:0] d;
        logic [31:0] r;
        for (int w = 0; w < 4; w++) begin
            d = next_rand();
            send_request(1'b1, line_addr(0, 13, w), 4'hf, d, "read_after_write");
            send_request(1'b0, line_addr(0, 13, w), 4'h0, 32'h0, "read_after_write");
            r = next_rand();
            d = next_rand();
            send_request(1'b1, line_addr(0, 13, w), r[3:0], d, "read_after_write");
            send_request(1'b0, line_addr(0, 13, w), 4'h0, 32'h0, "read_after_write");
        end
        d = next_rand();
        send_request(1'b1, line_addr(3, 13, 1), 4'hf, d, "read_after_write_miss");
        send_request(1'b0, line_addr(3, 13, 1), 4'h0, 32'h0, "read_after_write_miss");
        wait_all_done("read_after_write");
    endtask

    task automatic run_eviction_and_refill();
        logic [31:0] d;
        for (int t = 0; t < 4; t++) begin
            for (int w = 0; w < 4; w++) begin
                d = next_rand();
                send_request(1'b1, line_addr(t, 20, w), 4'hf, d, "eviction_writeback");
            end
        end
        for (int t = 0; t < 4; t++) begin
            for (int w = 0; w < 4; w++) begin
                send_request(1'b0, line_addr(t, 20, w), 4'h0, 32'h0, "eviction_writeback");
            end
        end
        // every read here misses, each offset taken twice
        for (int round = 0; round < 2; round++) begin
            for (int t = 0; t < 4; t++) begin
                send_request(1'b0, line_addr(t, 20, (round == 0) ? t : 3 - t), 4'h0, 32'h0,
                             "refill_word_position");
            end
        end
        wait_all_done("refill_word_position");
    endtask

    task automatic run_random_traffic(input int count);
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] d;
        for (int n = 0; n < count; n++) begin
            r = next_rand();
            d = next_rand();
            a = line_addr(int'(r[3:2]), 40 + int'(r[1:0]), int'(r[5:4]));
            if (!model_has(a)) begin
                send_request(1'b1, a, 4'hf, d, "random_traffic");  // first touch writes all bytes
            end else if (r[6]) begin
                send_request(1'b1, a, r[10:7], d, "random_traffic");
            end else begin
                send_request(1'b0, a, 4'h0, 32'h0, "random_traffic");
            end
        end
        wait_all_done("random_traffic");
    endtask

    initial begin
        rng_state = 32'hb14b_1db3;
        check_cnt = 0;
        err_cnt   = 0;
        timeouts  = 0;
        hung      = 1'b0;
        resetn    = 1'b0;
        valid     = 1'b0;
        op        = 1'b0;
        index     = '0;
        tag       = '0;
        offset    = '0;
        wstrb     = '0;
        wdata     = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        #40;
        check_value("reset_addr_ok", 32'h1, 32'(addr_ok));
        check_value("reset_data_ok", 32'h0, 32'(data_ok));
        check_value("reset_rd_req", 32'h0, 32'(dut_i.rd_req));
        check_value("reset_wr_req", 32'h0, 32'(dut_i.wr_req));
        check_value("reset_ret_valid", 32'h0, 32'(dut_i.ret_valid));
        check_value("reset_mem_ready", 32'h3, 32'({dut_i.rd_rdy, dut_i.wr_rdy}));

        run_fill_and_strobes();
        run_read_after_write();
        run_eviction_and_refill();
        run_random_traffic(2000);

        $display("checks %0d, errors %0d, timeouts %0d", check_cnt, err_cnt, timeouts);
        if (err_cnt == 0 && timeouts == 0 && check_cnt > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* logic/cache.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache (
    input  logic                 clk,
    input  logic                 resetn,
    // cpu side
    input  logic                 valid,
    input  logic                 op,      // 1 = write
    input  logic [`INDEX_W-1:0]  index,
    input  logic [`TAG_W-1:0]    tag,
    input  logic [`OFFSET_W-1:0] offset,
    input  cache_pkg::strb_t     wstrb,
    input  cache_pkg::word_t     wdata,
    output logic                 addr_ok,
    output logic                 data_ok,
    output cache_pkg::word_t     rdata,
    // memory side, whole lines only
    output logic                 rd_req,
    output cache_pkg::word_t     rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  logic                 ret_last,
    input  cache_pkg::word_t     ret_data,
    output logic                 wr_req,
    output cache_pkg::word_t     wr_addr,
    output cache_pkg::line_t     wr_data,
    input  logic                 wr_rdy
);

    localparam int WSEL_W = `OFFSET_W - 2;

    cache_pkg::main_state_t state, state_nx;
    cache_pkg::wbuf_state_t wb_state, wb_state_nx;

    // request buffer
    logic                 op_q;
    logic [`INDEX_W-1:0]  index_q;
    logic [`TAG_W-1:0]    tag_q;
    logic [`OFFSET_W-1:0] offset_q;
    cache_pkg::strb_t     wstrb_q;
    cache_pkg::word_t     wdata_q;

    // write buffer
    logic                 wb_way;
    logic [`INDEX_W-1:0]  wb_index;
    logic [WSEL_W-1:0]    wb_word;
    cache_pkg::strb_t     wb_strb;
    cache_pkg::word_t     wb_data;

    logic [1:0]           way_hit;
    logic                 tagv_we [2];
    cache_pkg::tagv_t     way_tagv [2];
    cache_pkg::tagv_t     new_tagv;
    cache_pkg::strb_t     way_we [2][`LINE_WORDS];
    cache_pkg::word_t     way_rdata [2][`LINE_WORDS];
    cache_pkg::word_t     bank_wdata [`LINE_WORDS];
    cache_pkg::word_t     merged;
    cache_pkg::word_t     hit_result;
    logic [`INDEX_W-1:0]  set_addr;

    logic [1:0][`SETS-1:0] dirty;
    logic [`SETS-1:0]      repl;    // victim way per set
    logic                  vict_way;
    logic                  vict_rd_ok;
    logic [WSEL_W-1:0]     ret_cnt;

    logic cache_hit, hit_write, refill_done, vict_dirty;
    logic read_same_q, drain_busy, conflict, accept;

    assign cache_hit   = |way_hit;
    assign hit_write   = (state == cache_pkg::lookup) && cache_hit && op_q;
    assign refill_done = (state == cache_pkg::refill) && ret_valid && ret_last;
    assign vict_dirty  = dirty[repl[index_q]][index_q] && way_tagv[repl[index_q]].v;

    // read of the word a write hit is about to buffer
    assign read_same_q = !op && (index == index_q)
                      && (offset[`OFFSET_W-1:2] == offset_q[`OFFSET_W-1:2]);
    // drain owns the set address this cycle
    assign drain_busy  = (wb_state == cache_pkg::wb_write)
                      && ((index != wb_index) || (!op && offset[`OFFSET_W-1:2] == wb_word));
    assign conflict    = (hit_write && read_same_q) || drain_busy;

    always_comb begin
        case (state)
            cache_pkg::idle:   addr_ok = !conflict;
            cache_pkg::lookup: addr_ok = cache_hit && !conflict;
            default:           addr_ok = 1'b0;
        endcase
    end

    assign accept = valid && addr_ok;

    always_comb begin
        state_nx = state;
        case (state)
            cache_pkg::idle: begin
                if (accept) state_nx = cache_pkg::lookup;
            end
            cache_pkg::lookup: begin
                if (cache_hit) begin
                    state_nx = accept ? cache_pkg::lookup : cache_pkg::idle;
                end else if (vict_dirty) begin
                    state_nx = cache_pkg::miss;
                end else begin
                    state_nx = cache_pkg::replace;
                end
            end
            cache_pkg::miss: begin
                if (wr_req) state_nx = cache_pkg::replace;
            end
            cache_pkg::replace: begin
                if (rd_rdy) state_nx = cache_pkg::refill;
            end
            cache_pkg::refill: begin
                if (refill_done) state_nx = cache_pkg::idle;
            end
            default: state_nx = cache_pkg::idle;
        endcase
    end

    assign wb_state_nx = hit_write ? cache_pkg::wb_write : cache_pkg::wb_idle;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= cache_pkg::idle;
            wb_state   <= cache_pkg::wb_idle;
            vict_rd_ok <= 1'b0;
            ret_cnt    <= '0;
        end else begin
            state      <= state_nx;
            wb_state   <= wb_state_nx;
            vict_rd_ok <= (state == cache_pkg::miss);  // banks now show the victim set
            if (state == cache_pkg::refill && ret_valid) begin
                ret_cnt <= ret_last ? '0 : ret_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q     <= op;
            index_q  <= index;
            tag_q    <= tag;
            offset_q <= offset;
            wstrb_q  <= wstrb;
            wdata_q  <= wdata;
        end
        if (hit_write) begin
            wb_way   <= way_hit[1];
            wb_index <= index_q;
            wb_word  <= offset_q[`OFFSET_W-1:2];
            wb_strb  <= wstrb_q;
            wb_data  <= wdata_q;
        end
        if (state == cache_pkg::lookup) begin
            vict_way <= repl[index_q];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            repl <= '0;
        end else if (state == cache_pkg::lookup && cache_hit) begin
            repl[index_q] <= way_hit[0];  // point away from the hit way
        end else if (refill_done) begin
            repl[index_q] <= ~vict_way;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            dirty <= '0;
        end else begin
            if (wb_state == cache_pkg::wb_write) dirty[wb_way][wb_index] <= 1'b1;
            if (refill_done) dirty[vict_way][index_q] <= op_q;
        end
    end

    // pending write bytes over the returned word
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            merged[8*k +: 8] = wstrb_q[k] ? wdata_q[8*k +: 8] : ret_data[8*k +: 8];
        end
    end

    always_comb begin
        for (int b = 0; b < `LINE_WORDS; b++) begin
            if (wb_state == cache_pkg::wb_write && wb_word == WSEL_W'(b)) begin
                bank_wdata[b] = wb_data;
            end else if (op_q && offset_q[`OFFSET_W-1:2] == WSEL_W'(b)) begin
                bank_wdata[b] = merged;
            end else begin
                bank_wdata[b] = ret_data;
            end
            for (int w = 0; w < 2; w++) begin
                way_we[w][b] = '0;
                if (wb_state == cache_pkg::wb_write && wb_word == WSEL_W'(b)
                        && wb_way == 1'(w)) begin
                    way_we[w][b] = wb_strb;
                end
                if (state == cache_pkg::refill && ret_valid && ret_cnt == WSEL_W'(b)
                        && vict_way == 1'(w)) begin
                    way_we[w][b] = '1;  // whole word per beat
                end
            end
        end
    end

    assign set_addr = (wb_state == cache_pkg::wb_write) ? wb_index :
                      (state == cache_pkg::idle || state == cache_pkg::lookup) ? index : index_q;

    assign new_tagv.tag = tag_q;
    assign new_tagv.v   = 1'b1;

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign tagv_we[w] = refill_done && (vict_way == 1'(w));

        cache_way u_way (
            .clk        (clk),
            .resetn     (resetn),
            .tagv_we    (tagv_we[w]),
            .addr       (set_addr),
            .tagv_wdata (new_tagv),
            .bank_we    (way_we[w]),
            .bank_wdata (bank_wdata),
            .req_tag    (tag_q),
            .hit        (way_hit[w]),
            .tagv       (way_tagv[w]),
            .bank_rdata (way_rdata[w])
        );
    end

    assign hit_result = way_hit[1] ? way_rdata[1][offset_q[`OFFSET_W-1:2]]
                                   : way_rdata[0][offset_q[`OFFSET_W-1:2]];

    assign data_ok = (state == cache_pkg::lookup && (cache_hit || op_q))
                  || (state == cache_pkg::refill && !op_q && ret_valid
                      && ret_cnt == offset_q[`OFFSET_W-1:2]);
    assign rdata   = (state == cache_pkg::refill) ? ret_data : hit_result;

    assign rd_req  = (state == cache_pkg::replace);
    assign rd_addr = {tag_q, index_q, {`OFFSET_W{1'b0}}};

    // one-cycle strobe, only once the victim set has been read
    assign wr_req  = (state == cache_pkg::miss) && vict_rd_ok && wr_rdy;
    assign wr_addr = {way_tagv[vict_way].tag, index_q, {`OFFSET_W{1'b0}}};
    assign wr_data = {way_rdata[vict_way][3], way_rdata[vict_way][2],
                      way_rdata[vict_way][1], way_rdata[vict_way][0]};

endmodule

/* logic/cache_pkg.sv */
`include "cache_settings.svh"

package cache_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    // word 0 sits in the low bits
    typedef logic [`LINE_WORDS*32-1:0] line_t;

    // tag ram payload
    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        logic              v;
    } tagv_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,     // dirty victim write-back
        replace,  // refill request
        refill
    } main_state_t;

    typedef enum logic {
        wb_idle,
        wb_write
    } wbuf_state_t;

endpackage

/* logic/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// address split: tag | index | offset
`define TAG_W       20
`define INDEX_W     8
`define OFFSET_W    4

// cache geometry
`define SETS        256
`define LINE_WORDS  4

// backing memory, line number taken from address bits 13..4
`define MEM_LINES   1024
`define MEM_LAT     3  // cycles from refill acceptance to first beat

`endif

/* logic/cache_sram.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_sram #(
    parameter type data_t = logic [7:0],
    parameter int  depth  = `SETS
) (
    input  logic                clk,
    input  logic                we,
    input  logic [`INDEX_W-1:0] addr,
    input  data_t               wdata,
    output data_t               rdata
);

    data_t mem [depth];

    // read-first, data valid one cycle after the address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

/* logic/cache_top.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_top (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 valid,
    input  logic                 op,
    input  logic [`INDEX_W-1:0]  index,
    input  logic [`TAG_W-1:0]    tag,
    input  logic [`OFFSET_W-1:0] offset,
    input  cache_pkg::strb_t     wstrb,
    input  cache_pkg::word_t     wdata,
    output logic                 addr_ok,
    output logic                 data_ok,
    output cache_pkg::word_t     rdata
);

    // refill and write-back wires
    logic             rd_req, rd_rdy, ret_valid, ret_last, wr_req, wr_rdy;
    cache_pkg::word_t rd_addr, ret_data, wr_addr;
    cache_pkg::line_t wr_data;

    cache u_cache (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    line_mem #(
        .ret_delay (`MEM_LAT)
    ) u_mem (
        .clk       (clk),
        .resetn    (resetn),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

endmodule

/* logic/cache_way.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_way (
    input  logic                clk,
    input  logic                resetn,
    input  logic                tagv_we,
    input  logic [`INDEX_W-1:0] addr,
    input  cache_pkg::tagv_t    tagv_wdata,
    input  cache_pkg::strb_t    bank_we [`LINE_WORDS],
    input  cache_pkg::word_t    bank_wdata [`LINE_WORDS],
    input  logic [`TAG_W-1:0]   req_tag,
    output logic                hit,
    output cache_pkg::tagv_t    tagv,
    output cache_pkg::word_t    bank_rdata [`LINE_WORDS]
);

    logic [`SETS-1:0]    valid_q;  // per-set valid, cleared at reset
    logic [`INDEX_W-1:0] addr_q;
    cache_pkg::tagv_t    tagv_ram;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= '0;
        end else if (tagv_we) begin
            valid_q[addr] <= tagv_wdata.v;
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= addr;  // follows the ram read latency
    end

    cache_sram #(
        .data_t (cache_pkg::tagv_t),
        .depth  (`SETS)
    ) u_tagv (
        .clk   (clk),
        .we    (tagv_we),
        .addr  (addr),
        .wdata (tagv_wdata),
        .rdata (tagv_ram)
    );

    // ram valid field is ignored, the register vector wins
    assign tagv.tag = tagv_ram.tag;
    assign tagv.v   = valid_q[addr_q];
    assign hit      = tagv.v && (tagv.tag == req_tag);

    // one byte ram per lane of every bank
    for (genvar b = 0; b < `LINE_WORDS; b++) begin : g_bank
        for (genvar k = 0; k < 4; k++) begin : g_byte
            cache_sram #(
                .data_t (cache_pkg::byte_t),
                .depth  (`SETS)
            ) u_byte (
                .clk   (clk),
                .we    (bank_we[b][k]),
                .addr  (addr),
                .wdata (bank_wdata[b][8*k +: 8]),
                .rdata (bank_rdata[b][8*k +: 8])
            );
        end
    end

endmodule

/* logic/line_mem.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module line_mem #(
    parameter int ret_delay = `MEM_LAT
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             rd_req,
    input  cache_pkg::word_t rd_addr,
    output logic             rd_rdy,
    output logic             ret_valid,
    output logic             ret_last,
    output cache_pkg::word_t ret_data,
    input  logic             wr_req,
    input  cache_pkg::word_t wr_addr,
    input  cache_pkg::line_t wr_data,
    output logic             wr_rdy
);

    localparam int LINE_AW = $clog2(`MEM_LINES);

    typedef enum logic [1:0] {
        ready,
        waiting,
        returning
    } mem_state_t;

    mem_state_t       state;
    cache_pkg::line_t lines [`MEM_LINES];
    logic [LINE_AW-1:0] rd_line;
    logic [LINE_AW-1:0] wr_line;
    cache_pkg::line_t   wr_line_data;
    logic               wr_pend;  // line lands at the end of this cycle
    logic [7:0]         lat_cnt;
    logic [1:0]         beat;

    assign rd_rdy    = (state == ready) && !wr_pend;
    assign wr_rdy    = (state == ready) && !wr_pend;
    assign ret_valid = (state == returning);
    assign ret_last  = ret_valid && (beat == 2'(`LINE_WORDS - 1));
    assign ret_data  = lines[rd_line][32*beat +: 32];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= ready;
            wr_pend <= 1'b0;
            lat_cnt <= '0;
            beat    <= '0;
        end else begin
            wr_pend <= wr_req && wr_rdy;
            case (state)
                ready: begin
                    if (rd_req && rd_rdy) begin
                        state   <= waiting;
                        lat_cnt <= 8'(ret_delay - 1);
                    end
                end
                waiting: begin
                    if (lat_cnt == '0) state <= returning;
                    else lat_cnt <= lat_cnt - 1'b1;
                end
                returning: begin
                    beat <= beat + 1'b1;  // wraps back to word 0
                    if (ret_last) state <= ready;
                end
                default: state <= ready;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req && rd_rdy) begin
            rd_line <= rd_addr[LINE_AW+`OFFSET_W-1:`OFFSET_W];
        end
        if (wr_req && wr_rdy) begin
            wr_line      <= wr_addr[LINE_AW+`OFFSET_W-1:`OFFSET_W];
            wr_line_data <= wr_data;
        end
        if (wr_pend) begin
            lines[wr_line] <= wr_line_data;
        end
    end

endmodule

/* sim.f */
+incdir+logic
+incdir+bench
logic/cache_pkg.sv
logic/cache_sram.sv
logic/cache_way.sv
logic/cache.sv
logic/line_mem.sv
logic/cache_top.sv
bench/cache_tb.sv
